// ==== src/jtag_pkg.sv ====
// Shared constants for the JTAG test access port
// Imported by the TAP blocks that need register lengths or instruction codes
package jtag_pkg;

  ////////////////////////////////////////
  // Instruction register
  ////////////////////////////////////////

  // Instruction register length
  localparam int unsigned IR_LEN = 4;

  // Fixed value loaded on Capture-IR
  // Low bits 01 as the standard asks, upper bits help spot stuck lines
  localparam logic [IR_LEN-1:0] IR_CAPTURE = 4'b0101;

  // Instruction codes
  localparam logic [IR_LEN-1:0] INSTR_EXTEST         = 4'b0000;
  localparam logic [IR_LEN-1:0] INSTR_SAMPLE_PRELOAD = 4'b0001;
  localparam logic [IR_LEN-1:0] INSTR_IDCODE         = 4'b0010;
  localparam logic [IR_LEN-1:0] INSTR_DEBUG          = 4'b1000;
  localparam logic [IR_LEN-1:0] INSTR_MBIST          = 4'b1001;
  // All ones, also the fallback for undefined codes
  localparam logic [IR_LEN-1:0] INSTR_BYPASS         = 4'b1111;

  ////////////////////////////////////////
  // Data registers
  ////////////////////////////////////////

  // Device identifier
  // Version 0001, part 0100100101010001, manufacturer 00011100001
  // Bit 0 always set
  localparam logic [31:0] IDCODE_VALUE = 32'h149511c3;

  // Debug user register length
  localparam int unsigned DBG_LEN = 8;

endpackage

// ==== src/tap_fsm.sv ====
// IEEE 1149.1 TAP controller, one flop per state
// Drives the state flags used by the IR, DR and TDO blocks
module tap_fsm (
  input  logic tck_pad_i,
  input  logic trst_pad_i,
  input  logic tms_pad_i,
  output logic test_logic_reset_o,
  output logic capture_ir_o,
  output logic shift_ir_o,
  output logic update_ir_o,
  output logic capture_dr_o,
  output logic shift_dr_o,
  output logic pause_dr_o,
  output logic update_dr_o
);

  // Current states
  logic test_logic_reset, run_test_idle;
  logic select_dr_scan, capture_dr, shift_dr, exit1_dr, pause_dr, exit2_dr, update_dr;
  logic select_ir_scan, capture_ir, shift_ir, exit1_ir, pause_ir, exit2_ir, update_ir;

  // Next states
  logic test_logic_reset_d, run_test_idle_d;
  logic select_dr_scan_d, capture_dr_d, shift_dr_d, exit1_dr_d, pause_dr_d;
  logic exit2_dr_d, update_dr_d;
  logic select_ir_scan_d, capture_ir_d, shift_ir_d, exit1_ir_d, pause_ir_d;
  logic exit2_ir_d, update_ir_d;

  // Last four TMS values
  logic [3:0] tms_hist;
  logic       tms_reset;

  ////////////////////////////////////////
  // TMS soft reset
  ////////////////////////////////////////

  always_ff @(posedge tck_pad_i or posedge trst_pad_i) begin
    if (trst_pad_i) begin
      tms_hist <= '0;
    end else begin
      tms_hist <= {tms_hist[2:0], tms_pad_i};
    end
  end

  // Fifth consecutive one forces Test-Logic-Reset
  assign tms_reset = (&tms_hist) & tms_pad_i;

  ////////////////////////////////////////
  // Next state, per state from predecessors
  ////////////////////////////////////////

  always_comb begin
    test_logic_reset_d = tms_pad_i & (test_logic_reset | select_ir_scan);
    run_test_idle_d    = ~tms_pad_i & (test_logic_reset | run_test_idle | update_dr | update_ir);
    // DR column
    select_dr_scan_d   = tms_pad_i & (run_test_idle | update_dr | update_ir);
    capture_dr_d       = ~tms_pad_i & select_dr_scan;
    shift_dr_d         = ~tms_pad_i & (capture_dr | shift_dr | exit2_dr);
    exit1_dr_d         = tms_pad_i & (capture_dr | shift_dr);
    pause_dr_d         = ~tms_pad_i & (exit1_dr | pause_dr);
    exit2_dr_d         = tms_pad_i & pause_dr;
    update_dr_d        = tms_pad_i & (exit1_dr | exit2_dr);
    // IR column
    select_ir_scan_d   = tms_pad_i & select_dr_scan;
    capture_ir_d       = ~tms_pad_i & select_ir_scan;
    shift_ir_d         = ~tms_pad_i & (capture_ir | shift_ir | exit2_ir);
    exit1_ir_d         = tms_pad_i & (capture_ir | shift_ir);
    pause_ir_d         = ~tms_pad_i & (exit1_ir | pause_ir);
    exit2_ir_d         = tms_pad_i & pause_ir;
    update_ir_d        = tms_pad_i & (exit1_ir | exit2_ir);
  end

  ////////////////////////////////////////
  // State flops
  ////////////////////////////////////////

  always_ff @(posedge tck_pad_i or posedge trst_pad_i) begin
    if (trst_pad_i) begin
      test_logic_reset <= 1'b1;
      {run_test_idle, select_dr_scan, capture_dr, shift_dr} <= '0;
      {exit1_dr, pause_dr, exit2_dr, update_dr}             <= '0;
      {select_ir_scan, capture_ir, shift_ir, exit1_ir}      <= '0;
      {pause_ir, exit2_ir, update_ir}                       <= '0;
    end else if (tms_reset) begin
      // Same landing point as the pin reset
      test_logic_reset <= 1'b1;
      {run_test_idle, select_dr_scan, capture_dr, shift_dr} <= '0;
      {exit1_dr, pause_dr, exit2_dr, update_dr}             <= '0;
      {select_ir_scan, capture_ir, shift_ir, exit1_ir}      <= '0;
      {pause_ir, exit2_ir, update_ir}                       <= '0;
    end else begin
      test_logic_reset <= test_logic_reset_d;
      run_test_idle    <= run_test_idle_d;
      select_dr_scan   <= select_dr_scan_d;
      capture_dr       <= capture_dr_d;
      shift_dr         <= shift_dr_d;
      exit1_dr         <= exit1_dr_d;
      pause_dr         <= pause_dr_d;
      exit2_dr         <= exit2_dr_d;
      update_dr        <= update_dr_d;
      select_ir_scan   <= select_ir_scan_d;
      capture_ir       <= capture_ir_d;
      shift_ir         <= shift_ir_d;
      exit1_ir         <= exit1_ir_d;
      pause_ir         <= pause_ir_d;
      exit2_ir         <= exit2_ir_d;
      update_ir        <= update_ir_d;
    end
  end

  // Flags used downstream
  assign test_logic_reset_o = test_logic_reset;
  assign capture_ir_o       = capture_ir;
  assign shift_ir_o         = shift_ir;
  assign update_ir_o        = update_ir;
  assign capture_dr_o       = capture_dr;
  assign shift_dr_o         = shift_dr;
  assign pause_dr_o         = pause_dr;
  assign update_dr_o        = update_dr;

endmodule

// ==== src/tap_ir_decode.sv ====
// Instruction register with update latch and instruction decode
// Serial bit goes to the TDO mux, selects go to data regs and the SoC
module tap_ir_decode
  import jtag_pkg::*;
(
  input  logic tck_pad_i,
  input  logic trst_pad_i,
  input  logic tdi_pad_i,
  input  logic test_logic_reset_i,
  input  logic capture_ir_i,
  input  logic shift_ir_i,
  input  logic update_ir_i,
  output logic ir_bit_o,
  output logic extest_sel_o,
  output logic sample_preload_sel_o,
  output logic idcode_sel_o,
  output logic debug_sel_o,
  output logic mbist_sel_o,
  output logic bypass_sel_o
);

  // Shift stage and active instruction
  logic [IR_LEN-1:0] ir_shift;
  logic [IR_LEN-1:0] ir_latched;

  ////////////////////////////////////////
  // Capture and shift
  ////////////////////////////////////////

  always_ff @(posedge tck_pad_i or posedge trst_pad_i) begin
    if (trst_pad_i) begin
      ir_shift <= '0;
    end else if (capture_ir_i) begin
      ir_shift <= IR_CAPTURE;
    end else if (shift_ir_i) begin
      // LSB first, TDI enters at the top
      ir_shift <= {tdi_pad_i, ir_shift[IR_LEN-1:1]};
    end
  end

  assign ir_bit_o = ir_shift[0];

  // Active instruction
  // IDCODE after pin reset and while in Test-Logic-Reset
  always_ff @(posedge tck_pad_i or posedge trst_pad_i) begin
    if (trst_pad_i) begin
      ir_latched <= INSTR_IDCODE;
    end else if (test_logic_reset_i) begin
      ir_latched <= INSTR_IDCODE;
    end else if (update_ir_i) begin
      ir_latched <= ir_shift;
    end
  end

  ////////////////////////////////////////
  // Decode, exactly one select high
  ////////////////////////////////////////

  always_comb begin
    extest_sel_o         = 1'b0;
    sample_preload_sel_o = 1'b0;
    idcode_sel_o         = 1'b0;
    debug_sel_o          = 1'b0;
    mbist_sel_o          = 1'b0;
    bypass_sel_o         = 1'b0;
    case (ir_latched)
      INSTR_EXTEST:         extest_sel_o = 1'b1;
      INSTR_SAMPLE_PRELOAD: sample_preload_sel_o = 1'b1;
      INSTR_IDCODE:         idcode_sel_o = 1'b1;
      INSTR_DEBUG:          debug_sel_o = 1'b1;
      INSTR_MBIST:          mbist_sel_o = 1'b1;
      // BYPASS and every undefined code
      default:              bypass_sel_o = 1'b1;
    endcase
  end

endmodule

// ==== src/tap_data_regs.sv ====
// Internal data registers of the TAP: IDCODE, BYPASS and the DEBUG user register
// Each register shifts only while its instruction is selected
module tap_data_regs
  import jtag_pkg::*;
(
  input  logic               tck_pad_i,
  input  logic               trst_pad_i,
  input  logic               tdi_pad_i,
  input  logic               capture_dr_i,
  input  logic               shift_dr_i,
  input  logic               update_dr_i,
  input  logic               idcode_sel_i,
  input  logic               debug_sel_i,
  input  logic               bypass_sel_i,
  output logic               idcode_bit_o,
  output logic               bypass_bit_o,
  output logic               debug_bit_o,
  output logic [DBG_LEN-1:0] debug_data_o
);

  logic [31:0]        idcode_reg;
  logic               bypass_reg;
  logic [DBG_LEN-1:0] debug_shift;

  ////////////////////////////////////////
  // IDCODE
  ////////////////////////////////////////

  always_ff @(posedge tck_pad_i) begin
    if (idcode_sel_i) begin
      if (capture_dr_i) begin
        idcode_reg <= IDCODE_VALUE;
      end else if (shift_dr_i) begin
        idcode_reg <= {tdi_pad_i, idcode_reg[31:1]};
      end
    end
  end

  assign idcode_bit_o = idcode_reg[0];

  ////////////////////////////////////////
  // BYPASS
  ////////////////////////////////////////

  // Single stage, captures 0 so the host can count the chain
  always_ff @(posedge tck_pad_i or posedge trst_pad_i) begin
    if (trst_pad_i) begin
      bypass_reg <= 1'b0;
    end else if (bypass_sel_i) begin
      if (capture_dr_i) begin
        bypass_reg <= 1'b0;
      end else if (shift_dr_i) begin
        bypass_reg <= tdi_pad_i;
      end
    end
  end

  assign bypass_bit_o = bypass_reg;

  ////////////////////////////////////////
  // DEBUG
  ////////////////////////////////////////

  // Shift stage
  // Capture loads the current output word for read-back
  always_ff @(posedge tck_pad_i) begin
    if (debug_sel_i) begin
      if (capture_dr_i) begin
        debug_shift <= debug_data_o;
      end else if (shift_dr_i) begin
        debug_shift <= {tdi_pad_i, debug_shift[DBG_LEN-1:1]};
      end
    end
  end

  assign debug_bit_o = debug_shift[0];

  // Update latch toward the system
  // Holds its word until the next Update-DR under DEBUG
  always_ff @(posedge tck_pad_i or posedge trst_pad_i) begin
    if (trst_pad_i) begin
      debug_data_o <= '0;
    end else if (update_dr_i && debug_sel_i) begin
      debug_data_o <= debug_shift;
    end
  end

endmodule

// ==== src/tap_tdo_mux.sv ====
// TDO source selection, retimed on the falling edge of TCK
// Also drives the pad output enable
module tap_tdo_mux (
  input  logic tck_pad_i,
  input  logic trst_pad_i,
  input  logic shift_ir_i,
  input  logic shift_dr_i,
  input  logic pause_dr_i,
  input  logic ir_bit_i,
  input  logic idcode_bit_i,
  input  logic bypass_bit_i,
  input  logic debug_bit_i,
  input  logic bs_chain_tdi_i,
  input  logic mbist_tdi_i,
  input  logic extest_sel_i,
  input  logic sample_preload_sel_i,
  input  logic idcode_sel_i,
  input  logic debug_sel_i,
  input  logic mbist_sel_i,
  output logic tdo_pad_o,
  output logic tdo_padoe_o
);

  // Falling-edge copies
  logic ir_bit_q, idcode_bit_q, bypass_bit_q, debug_bit_q;
  logic shift_ir_q;
  logic extest_q, sample_preload_q, idcode_q, debug_q, mbist_q;

  always_ff @(negedge tck_pad_i or posedge trst_pad_i) begin
    if (trst_pad_i) begin
      {ir_bit_q, idcode_bit_q, bypass_bit_q, debug_bit_q} <= '0;
      shift_ir_q <= 1'b0;
      {extest_q, sample_preload_q, idcode_q, debug_q, mbist_q} <= '0;
      tdo_padoe_o <= 1'b0;
    end else begin
      ir_bit_q         <= ir_bit_i;
      idcode_bit_q     <= idcode_bit_i;
      bypass_bit_q     <= bypass_bit_i;
      debug_bit_q      <= debug_bit_i;
      shift_ir_q       <= shift_ir_i;
      extest_q         <= extest_sel_i;
      sample_preload_q <= sample_preload_sel_i;
      idcode_q         <= idcode_sel_i;
      debug_q          <= debug_sel_i;
      mbist_q          <= mbist_sel_i;
      // Enable also held through Pause-DR under DEBUG
      tdo_padoe_o      <= shift_ir_i | shift_dr_i | (pause_dr_i & debug_sel_i);
    end
  end

  // Source select
  // External chains return already retimed data
  always_comb begin
    if (shift_ir_q) begin
      tdo_pad_o = ir_bit_q;
    end else if (idcode_q) begin
      tdo_pad_o = idcode_bit_q;
    end else if (debug_q) begin
      tdo_pad_o = debug_bit_q;
    end else if (extest_q || sample_preload_q) begin
      tdo_pad_o = bs_chain_tdi_i;
    end else if (mbist_q) begin
      tdo_pad_o = mbist_tdi_i;
    end else begin
      tdo_pad_o = bypass_bit_q;
    end
  end

endmodule

// ==== src/tap_top.sv ====
// Top level of the JTAG TAP, wires controller, IR, data regs and TDO mux
// Pads on one side, external boundary-scan and MBIST chains on the other
module tap_top
  import jtag_pkg::*;
(
  input  logic               tck_pad_i,
  input  logic               trst_pad_i,
  input  logic               tms_pad_i,
  input  logic               tdi_pad_i,
  input  logic               bs_chain_tdi_i,
  input  logic               mbist_tdi_i,
  output logic               tdo_pad_o,
  output logic               tdo_padoe_o,
  output logic               tdo_o,
  output logic               shift_dr_o,
  output logic               capture_dr_o,
  output logic               update_dr_o,
  output logic               extest_select_o,
  output logic               sample_preload_select_o,
  output logic               mbist_select_o,
  output logic [DBG_LEN-1:0] debug_data_o
);

  // State flags
  logic test_logic_reset, capture_ir, shift_ir, update_ir, pause_dr;
  // Instruction selects
  logic idcode_sel, debug_sel, bypass_sel;
  // Serial bits toward TDO
  logic ir_bit, idcode_bit, bypass_bit, debug_bit;

  // TDI feeds the external chains directly
  assign tdo_o = tdi_pad_i;

  // Decode, state machine
  tap_fsm i_tap_fsm (
    .tck_pad_i,
    .trst_pad_i,
    .tms_pad_i,
    .test_logic_reset_o (test_logic_reset),
    .capture_ir_o       (capture_ir),
    .shift_ir_o         (shift_ir),
    .update_ir_o        (update_ir),
    .capture_dr_o       (capture_dr_o),
    .shift_dr_o         (shift_dr_o),
    .pause_dr_o         (pause_dr),
    .update_dr_o        (update_dr_o)
  );

  // Decode, instruction
  tap_ir_decode i_tap_ir_decode (
    .tck_pad_i,
    .trst_pad_i,
    .tdi_pad_i,
    .test_logic_reset_i   (test_logic_reset),
    .capture_ir_i         (capture_ir),
    .shift_ir_i           (shift_ir),
    .update_ir_i          (update_ir),
    .ir_bit_o             (ir_bit),
    .extest_sel_o         (extest_select_o),
    .sample_preload_sel_o (sample_preload_select_o),
    .idcode_sel_o         (idcode_sel),
    .debug_sel_o          (debug_sel),
    .mbist_sel_o          (mbist_select_o),
    .bypass_sel_o         (bypass_sel)
  );

  // Execute, data registers
  tap_data_regs i_tap_data_regs (
    .tck_pad_i,
    .trst_pad_i,
    .tdi_pad_i,
    .capture_dr_i (capture_dr_o),
    .shift_dr_i   (shift_dr_o),
    .update_dr_i  (update_dr_o),
    .idcode_sel_i (idcode_sel),
    .debug_sel_i  (debug_sel),
    .bypass_sel_i (bypass_sel),
    .idcode_bit_o (idcode_bit),
    .bypass_bit_o (bypass_bit),
    .debug_bit_o  (debug_bit),
    .debug_data_o
  );

  // Result, TDO path
  tap_tdo_mux i_tap_tdo_mux (
    .tck_pad_i,
    .trst_pad_i,
    .shift_ir_i           (shift_ir),
    .shift_dr_i           (shift_dr_o),
    .pause_dr_i           (pause_dr),
    .ir_bit_i             (ir_bit),
    .idcode_bit_i         (idcode_bit),
    .bypass_bit_i         (bypass_bit),
    .debug_bit_i          (debug_bit),
    .bs_chain_tdi_i,
    .mbist_tdi_i,
    .extest_sel_i         (extest_select_o),
    .sample_preload_sel_i (sample_preload_select_o),
    .idcode_sel_i         (idcode_sel),
    .debug_sel_i          (debug_sel),
    .mbist_sel_i          (mbist_select_o),
    .tdo_pad_o,
    .tdo_padoe_o
  );

endmodule

// ==== testbench/tap_checker.sv ====
// Scoreboard of the TAP testbench that collects TDO over each enabled window
// Compares each scan and, on request, the debug word, selects and DR flags
module tap_checker
  import jtag_pkg::*;
(
  input  logic               tck_pad_i,
  input  logic               trst_pad_i,
  // DUT outputs under watch
  input  logic               tdo_pad_i,
  input  logic               tdo_padoe_i,
  input  logic               shift_dr_i,
  input  logic               capture_dr_i,
  input  logic               update_dr_i,
  input  logic [DBG_LEN-1:0] debug_data_i,
  input  logic               extest_select_i,
  input  logic               sample_preload_select_i,
  input  logic               mbist_select_i,
  // Expected values from the stimulus side
  input  logic [5:0]         exp_len_i,
  input  logic [31:0]        exp_word_i,
  input  logic [5:0]         exp_dr_len_i,
  input  logic [DBG_LEN-1:0] exp_debug_i,
  input  logic [2:0]         exp_sel_i,
  input  logic               status_req_i,
  // Progress and error counts
  output int                 scans_done_o,
  output int                 status_done_o,
  output int                 mismatches_o
);

  timeunit 1ns;
  timeprecision 1ps;

  // Current TDO window
  logic        in_scan;
  logic [31:0] tdo_word;
  int          bit_count;
  // DR flag cycles since the last status snapshot
  int          capture_cycles;
  int          shift_cycles;
  int          update_cycles;

  always @(posedge tck_pad_i or posedge trst_pad_i) begin
    int errs;
    int exp_visits;
    errs = 0;
    exp_visits = (exp_dr_len_i != 0) ? 1 : 0;
    if (trst_pad_i) begin
      in_scan        <= 1'b0;
      tdo_word       <= '0;
      bit_count      <= 0;
      capture_cycles <= 0;
      shift_cycles   <= 0;
      update_cycles  <= 0;
      scans_done_o   <= 0;
      status_done_o  <= 0;
      mismatches_o   <= 0;
    end else begin
      ////////////////////////////////////////
      // Scan windows
      ////////////////////////////////////////
      if (tdo_padoe_i) begin
        // One TDO bit per shift edge starting at the LSB
        if (bit_count < 32) begin
          tdo_word[bit_count] <= tdo_pad_i;
        end
        bit_count <= bit_count + 1;
        in_scan   <= 1'b1;
      end else if (in_scan) begin
        // Enable dropped so the window is complete
        if (bit_count != exp_len_i || tdo_word !== exp_word_i) begin
          $display("FAIL %0t: scan %0d shifted out %0d bits %h, expected %0d bits %h",
                   $time, scans_done_o, bit_count, tdo_word, exp_len_i, exp_word_i);
          errs++;
        end
        in_scan      <= 1'b0;
        tdo_word     <= '0;
        bit_count    <= 0;
        scans_done_o <= scans_done_o + 1;
      end

      // DR state flags
      if (capture_dr_i) begin
        capture_cycles <= capture_cycles + 1;
      end
      if (shift_dr_i) begin
        shift_cycles <= shift_cycles + 1;
      end
      if (update_dr_i) begin
        update_cycles <= update_cycles + 1;
      end

      ////////////////////////////////////////
      // Status snapshot
      ////////////////////////////////////////
      if (status_req_i) begin
        // TAP idle in Run-Test-Idle so TDO enable and DR flags are low
        if ({tdo_padoe_i, capture_dr_i, shift_dr_i, update_dr_i} !== 4'b0000) begin
          $display("FAIL %0t: TDO enable or a DR flag is high outside a scan", $time);
          errs++;
        end
        if (debug_data_i !== exp_debug_i) begin
          $display("FAIL %0t: debug word is %h, expected %h",
                   $time, debug_data_i, exp_debug_i);
          errs++;
        end
        // Order extest, sample_preload, mbist
        if ({extest_select_i, sample_preload_select_i, mbist_select_i} !== exp_sel_i) begin
          $display("FAIL %0t: selects are %b, expected %b", $time,
                   {extest_select_i, sample_preload_select_i, mbist_select_i}, exp_sel_i);
          errs++;
        end
        // One Capture-DR and one Update-DR around each DR scan
        if (capture_cycles != exp_visits || shift_cycles != int'(exp_dr_len_i) ||
            update_cycles != exp_visits) begin
          $display("FAIL %0t: capture/shift/update cycles %0d/%0d/%0d, expected %0d/%0d/%0d",
                   $time, capture_cycles, shift_cycles, update_cycles,
                   exp_visits, exp_dr_len_i, exp_visits);
          errs++;
        end
        capture_cycles <= 0;
        shift_cycles   <= 0;
        update_cycles  <= 0;
        status_done_o  <= status_done_o + 1;
      end
      mismatches_o <= mismatches_o + errs;
    end
  end

endmodule

// ==== testbench/tb_tap_top.sv ====
// Testbench for the JTAG TAP that replays the scan operations of the golden file
// Drives TMS and TDI and loops the external chains back while the checker compares
module tb_tap_top
  import jtag_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int num_fields  = 7;
  localparam int max_ops     = 32;
  localparam int wait_cycles = 100;
  // Capture-IR pattern 0101
  localparam logic [IR_LEN-1:0] ir_capture_exp = 4'b0101;

  // Pads and chain loopback
  logic tck_pad, trst_pad, tms_pad, tdi_pad;
  logic tdo_pad, tdo_padoe, tdo_chain;
  logic bs_chain_tdi, mbist_tdi;
  // Remaining DUT outputs
  logic shift_dr, capture_dr, update_dr;
  logic extest_select, sample_preload_select, mbist_select;
  logic [DBG_LEN-1:0] debug_data;

  // Expected values toward the checker
  logic [5:0]         exp_len;
  logic [31:0]        exp_word;
  logic [5:0]         exp_dr_len;
  logic [DBG_LEN-1:0] exp_debug;
  logic [2:0]         exp_sel;
  logic               status_req;
  int                 scans_done, status_done, mismatches;

  // Golden operations of num_fields words each
  logic [31:0] golden [0:num_fields*max_ops-1];
  int          timeouts, file_errors, ops_run;

  // External chains modeled as wires from TDI
  assign bs_chain_tdi = tdo_chain;
  assign mbist_tdi    = tdo_chain;

  tap_top i_dut (
    .tck_pad_i               (tck_pad),
    .trst_pad_i              (trst_pad),
    .tms_pad_i               (tms_pad),
    .tdi_pad_i               (tdi_pad),
    .bs_chain_tdi_i          (bs_chain_tdi),
    .mbist_tdi_i             (mbist_tdi),
    .tdo_pad_o               (tdo_pad),
    .tdo_padoe_o             (tdo_padoe),
    .tdo_o                   (tdo_chain),
    .shift_dr_o              (shift_dr),
    .capture_dr_o            (capture_dr),
    .update_dr_o             (update_dr),
    .extest_select_o         (extest_select),
    .sample_preload_select_o (sample_preload_select),
    .mbist_select_o          (mbist_select),
    .debug_data_o            (debug_data)
  );

  tap_checker i_checker (
    .tck_pad_i               (tck_pad),
    .trst_pad_i              (trst_pad),
    .tdo_pad_i               (tdo_pad),
    .tdo_padoe_i             (tdo_padoe),
    .shift_dr_i              (shift_dr),
    .capture_dr_i            (capture_dr),
    .update_dr_i             (update_dr),
    .debug_data_i            (debug_data),
    .extest_select_i         (extest_select),
    .sample_preload_select_i (sample_preload_select),
    .mbist_select_i          (mbist_select),
    .exp_len_i               (exp_len),
    .exp_word_i              (exp_word),
    .exp_dr_len_i            (exp_dr_len),
    .exp_debug_i             (exp_debug),
    .exp_sel_i               (exp_sel),
    .status_req_i            (status_req),
    .scans_done_o            (scans_done),
    .status_done_o           (status_done),
    .mismatches_o            (mismatches)
  );

  // 20 ns TCK
  initial begin
    tck_pad = 1'b0;
    forever begin
      #10 tck_pad = ~tck_pad;
    end
  end

  ////////////////////////////////////////
  // TAP sequencing
  ////////////////////////////////////////

  // Values take effect on the following rising edge
  task automatic tap_step(input logic tms_val, input logic tdi_val);
    @(posedge tck_pad);
    #2;
    tms_pad = tms_val;
    tdi_pad = tdi_val;
  endtask

  // Shifts LSB first and leaves the shift state with TMS high on the last bit
  task automatic shift_bits(input logic [31:0] din, input int len);
    for (int i = 0; i < len; i++) begin
      tap_step(i == len - 1, din[i]);
    end
  endtask

  // Bounded wait for the checker to close a TDO window
  task automatic wait_scan(input int prev, input string what);
    int cycles;
    cycles = 0;
    while (scans_done == prev && cycles < wait_cycles) begin
      @(posedge tck_pad);
      cycles++;
    end
    if (scans_done == prev) begin
      $display("Timed out at %0t waiting for the %s scan to finish", $time, what);
      timeouts++;
    end
  endtask

  // Run-Test-Idle to Run-Test-Idle through Shift-IR
  task automatic ir_scan(input logic [IR_LEN-1:0] instr);
    int prev;
    prev     = scans_done;
    exp_len  = IR_LEN;
    exp_word = ir_capture_exp;
    tap_step(1'b1, 1'b0);
    tap_step(1'b1, 1'b0);
    tap_step(1'b0, 1'b0);
    tap_step(1'b0, 1'b0);
    shift_bits(instr, IR_LEN);
    tap_step(1'b1, 1'b0);
    tap_step(1'b0, 1'b0);
    wait_scan(prev, "IR");
  endtask

  // DR scan that may leave through five TMS ones to Test-Logic-Reset
  task automatic dr_scan(input logic [31:0] din, input int len, input logic [31:0] dout,
                         input logic soft_reset);
    int prev;
    prev       = scans_done;
    exp_len    = len;
    exp_word   = dout;
    exp_dr_len = len;
    tap_step(1'b1, 1'b0);
    tap_step(1'b0, 1'b0);
    tap_step(1'b0, 1'b0);
    shift_bits(din, len);
    if (soft_reset) begin
      // Four more ones after the one leaving Shift-DR
      repeat (4) tap_step(1'b1, 1'b0);
    end else begin
      tap_step(1'b1, 1'b0);
    end
    tap_step(1'b0, 1'b0);
    wait_scan(prev, "DR");
  endtask

  // One-edge request for the checker's status compare
  task automatic check_status(input logic [DBG_LEN-1:0] dbg, input logic [2:0] sel);
    int prev;
    int cycles;
    prev      = status_done;
    cycles    = 0;
    exp_debug = dbg;
    exp_sel   = sel;
    @(posedge tck_pad);
    #2;
    status_req = 1'b1;
    @(posedge tck_pad);
    #2;
    status_req = 1'b0;
    while (status_done == prev && cycles < wait_cycles) begin
      @(posedge tck_pad);
      cycles++;
    end
    if (status_done == prev) begin
      $display("Timed out at %0t waiting for the status check", $time);
      timeouts++;
    end
  endtask

  // Modes 0 IR+DR, 1 DR only, 2 IR+DR ending in soft reset, 3 status only
  task automatic run_op(input logic [31:0] mode, input logic [IR_LEN-1:0] instr,
                        input int len, input logic [31:0] din, input logic [31:0] dout,
                        input logic [DBG_LEN-1:0] dbg, input logic [2:0] sel);
    exp_dr_len = '0;
    case (mode)
      0: begin
        ir_scan(instr);
        dr_scan(din, len, dout, 1'b0);
      end
      1: dr_scan(din, len, dout, 1'b0);
      2: begin
        ir_scan(instr);
        dr_scan(din, len, dout, 1'b1);
      end
      3: begin
        // Status snapshot only
      end
      default: begin
        $display("Golden file holds unknown mode %0h", mode);
        file_errors++;
      end
    endcase
    check_status(dbg, sel);
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    int          base;
    logic [31:0] mode;
    logic        stop;
    trst_pad    = 1'b1;
    tms_pad     = 1'b0;
    tdi_pad     = 1'b0;
    status_req  = 1'b0;
    exp_len     = '0;
    exp_word    = '0;
    exp_dr_len  = '0;
    exp_debug   = '0;
    exp_sel     = '0;
    timeouts    = 0;
    file_errors = 0;
    ops_run     = 0;
    stop        = 1'b0;
    $readmemh("testbench/tap_golden.txt", golden);
    repeat (3) @(posedge tck_pad);
    #2;
    trst_pad = 1'b0;
    for (int op = 0; op < max_ops && !stop; op++) begin
      base = op * num_fields;
      mode = golden[base];
      if ($isunknown(mode)) begin
        $display("Golden file entry %0d is missing or unreadable", op);
        file_errors++;
        stop = 1'b1;
      end else if (mode == 32'hf) begin
        stop = 1'b1;
      end else begin
        run_op(mode, golden[base+1][IR_LEN-1:0], golden[base+2], golden[base+3],
               golden[base+4], golden[base+5][DBG_LEN-1:0], golden[base+6][2:0]);
        ops_run++;
        // A stuck TAP makes later results meaningless
        if (timeouts != 0) begin
          stop = 1'b1;
        end
      end
    end
    if (ops_run == 0) begin
      $display("No golden operations were run");
      file_errors++;
    end
    $write("Summary: %0d operations, %0d scans, %0d status checks, ",
           ops_run, scans_done, status_done);
    $display("%0d mismatches, %0d timeouts, %0d file errors",
             mismatches, timeouts, file_errors);
    if (mismatches == 0 && timeouts == 0 && file_errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
src/jtag_pkg.sv
src/tap_fsm.sv
src/tap_ir_decode.sv
src/tap_data_regs.sv
src/tap_tdo_mux.sv
src/tap_top.sv
testbench/tap_checker.sv
testbench/tb_tap_top.sv

// ==== Bender.yml ====
package:
  name: jtag_tap

sources:
  # Package first, then the TAP blocks, top level last
  - src/jtag_pkg.sv
  - src/tap_fsm.sv
  - src/tap_ir_decode.sv
  - src/tap_data_regs.sv
  - src/tap_tdo_mux.sv
  - src/tap_top.sv

  - target: simulation
    files:
      - testbench/tap_checker.sv
      - testbench/tb_tap_top.sv

// ==== testbench/tap_golden.txt ====
// Columns, all hex: mode instr len din dout dbg sel, sel is {extest, sample_preload, mbist}
// Mode 0 IR+DR, 1 DR only, 2 IR+DR ending in five TMS ones, 3 status only, f ends the list
3 0 00 00000000 00000000 00 0
// IDCODE is the default instruction
1 0 20 00000000 149511c3 00 0
0 2 20 a5a5a5a5 149511c3 00 0
// BYPASS and undefined 0111 return 0 then the input
0 f 08 000000b6 0000006c 00 0
0 7 10 00001234 00002468 00 0
0 f 01 00000001 00000000 00 0
// DEBUG write and read back
0 8 08 0000003c 00000000 3c 0
0 8 08 000000c5 0000003c c5 0
1 8 08 0000005a 000000c5 5a 0
// External chains through the loopback
0 0 10 0000beef 0000beef 5a 4
0 1 0c 00000abc 00000abc 5a 2
0 9 18 00c0ffee 00c0ffee 5a 1
0 f 20 80000001 00000002 5a 0
// Soft reset from Shift-DR, then IDCODE again
2 f 01 00000001 00000000 5a 0
1 0 20 ffffffff 149511c3 5a 0
0 8 08 00000000 0000005a 00 0
f 0 00 00000000 00000000 00 0
